/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = lsu_tb
FILELIST = lsu_top.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* logic/lsu_bus_pkg.sv */
// LSU data bus definitions

package lsu_bus_pkg;

  //////////////////////////////////////////////////
  // widths with a meaning on the bus side
  //////////////////////////////////////////////////

  typedef logic [31:0] addr_t;  // byte address
  typedef logic [31:0] word_t;  // one bus data word
  typedef logic [3:0]  be_t;    // one enable per byte lane

  // outstanding transfer count, 0 up to MAX_OUTSTANDING
  typedef logic [1:0] cnt_t;

  // transfers allowed in flight before the request is held off
  localparam cnt_t MAX_OUTSTANDING = 2'd2;

  //////////////////////////////////////////////////
  // address phase
  //////////////////////////////////////////////////

  // everything that must stay stable while req is high and gnt is low
  typedef struct packed {
    addr_t addr;   // word aligned on the second half of a split access
    logic  we;     // 1 = store
    be_t   be;     // byte lanes touched by this transfer
    word_t wdata;  // already rotated into the target lanes
  } bus_req_t;     // 69 bits

endpackage

/* logic/lsu_op_pkg.sv */
// LSU execute-side encodings

package lsu_op_pkg;

  //////////////////////////////////////////////////
  // access size
  //////////////////////////////////////////////////

  typedef logic [1:0] lsu_type_t;

  localparam lsu_type_t TYPE_WORD = 2'b00;
  localparam lsu_type_t TYPE_HALF = 2'b01;
  localparam lsu_type_t TYPE_BYTE = 2'b10;  // 2'b11 is a byte as well, bit 1 marks it

  //////////////////////////////////////////////////
  // load extension
  //////////////////////////////////////////////////

  typedef logic [1:0] ext_mode_t;

  localparam ext_mode_t EXT_ZERO = 2'b00;  // fill with zeros
  localparam ext_mode_t EXT_ONES = 2'b10;  // fill with ones
  // 01 and 11 copy the sign bit

  typedef logic [1:0] offset_t;  // byte position inside a word

  //////////////////////////////////////////////////
  // execute stage request
  //////////////////////////////////////////////////

  typedef struct packed {
    logic                 we;          // store when set
    lsu_type_t            size;        // word, half or byte
    lsu_bus_pkg::word_t   wdata;       // store data as held in the register
    offset_t              reg_offset;  // byte of the register that holds the lsb
    ext_mode_t            ext;         // extension for loads
    lsu_bus_pkg::addr_t   operand_a;   // base address
    lsu_bus_pkg::addr_t   operand_b;   // offset added when use_incr is set
    logic                 use_incr;    // address is a + b instead of a
    logic                 misaligned;  // this is the second half of a split access
  } ex_req_t;

  // kept from acceptance until the matching rvalid
  typedef struct packed {
    lsu_type_t size;
    offset_t   offset;  // low address bits of the access
    ext_mode_t ext;
    logic      we;
  } wb_ctrl_t;  // 7 bits

endpackage

/* logic/lsu_rdata_align.sv */
// LSU read data aligner

`timescale 1ns/1ps

module lsu_rdata_align (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rvalid_i,
  input  lsu_bus_pkg::word_t   rdata_i,         // raw bus word
  input  lsu_op_pkg::wb_ctrl_t wb_ctrl_i,       // control of the access answered now
  input  logic                 second_phase_i,  // EX holds the second half
  input  logic                 misaligned_i,    // EX holds a first half that splits
  output lsu_bus_pkg::word_t   rdata_o
);

  lsu_bus_pkg::word_t rdata_q;   // last result, or first word of a split load
  lsu_bus_pkg::word_t w_ext;     // word, joined across two words if split
  lsu_bus_pkg::word_t h_ext;
  lsu_bus_pkg::word_t b_ext;
  lsu_bus_pkg::word_t result;
  logic [15:0]        h_raw;
  logic [7:0]         b_raw;
  logic               is_byte;

  // fill bit for the upper part of an extended value
  function automatic logic fill_bit(input lsu_op_pkg::ext_mode_t ext, input logic msb);
    if (ext == lsu_op_pkg::EXT_ZERO) begin
      return 1'b0;
    end else if (ext == lsu_op_pkg::EXT_ONES) begin
      return 1'b1;
    end else begin
      return msb;  // sign
    end
  endfunction

  //////////////////////////////////////////////////
  // lane selection
  //////////////////////////////////////////////////

  // low lanes of the new word sit above the saved upper lanes
  always_comb begin
    case (wb_ctrl_i.offset)
      2'b00:   w_ext = rdata_i;
      2'b01:   w_ext = {rdata_i[7:0],  rdata_q[31:8]};
      2'b10:   w_ext = {rdata_i[15:0], rdata_q[31:16]};
      default: w_ext = {rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb begin
    case (wb_ctrl_i.offset)
      2'b00:   h_raw = rdata_i[15:0];
      2'b01:   h_raw = rdata_i[23:8];
      2'b10:   h_raw = rdata_i[31:16];
      default: h_raw = {rdata_i[7:0], rdata_q[31:24]};  // crosses into the next word
    endcase
  end

  assign b_raw = rdata_i[{wb_ctrl_i.offset, 3'b000} +: 8];  // bytes never split

  //////////////////////////////////////////////////
  // extension and result
  //////////////////////////////////////////////////

  assign h_ext = {{16{fill_bit(wb_ctrl_i.ext, h_raw[15])}}, h_raw};
  assign b_ext = {{24{fill_bit(wb_ctrl_i.ext, b_raw[7])}}, b_raw};

  assign is_byte = (wb_ctrl_i.size & lsu_op_pkg::TYPE_BYTE) != 2'b00;

  always_comb begin
    if (is_byte) begin
      result = b_ext;
    end else if (wb_ctrl_i.size == lsu_op_pkg::TYPE_HALF) begin
      result = h_ext;
    end else begin
      result = w_ext;
    end
  end

  // keep the raw word while a split load waits for its second half
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (rvalid_i && !wb_ctrl_i.we) begin
      if (second_phase_i || misaligned_i) begin
        rdata_q <= rdata_i;
      end else begin
        rdata_q <= result;  // held for the register file between responses
      end
    end
  end

  assign rdata_o = rvalid_i ? result : rdata_q;

endmodule

/* logic/lsu_req_format.sv */
// LSU request formatter

`timescale 1ns/1ps

module lsu_req_format (
  input  lsu_op_pkg::ex_req_t   ex_i,          // request fields from EX
  output lsu_bus_pkg::bus_req_t bus_req_o,     // address phase to the bus
  output lsu_op_pkg::wb_ctrl_t  wb_ctrl_o,     // candidate for the WB register
  output logic                  misaligned_o   // a second transfer is needed
);

  lsu_bus_pkg::addr_t addr_int;      // unaligned byte address
  lsu_op_pkg::offset_t addr_off;     // its low bits
  lsu_op_pkg::offset_t wdata_off;    // lane rotation for store data
  lsu_bus_pkg::be_t    be;
  lsu_bus_pkg::word_t  wdata_rot;
  logic                is_byte;

  //////////////////////////////////////////////////
  // address
  //////////////////////////////////////////////////

  assign addr_int = ex_i.use_incr ? (ex_i.operand_a + ex_i.operand_b) : ex_i.operand_a;
  assign addr_off = addr_int[1:0];

  // both byte encodings have bit 1 set
  assign is_byte = (ex_i.size & lsu_op_pkg::TYPE_BYTE) != 2'b00;

  //////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////

  always_comb begin
    if (is_byte) begin
      be = 4'b0001 << addr_off;  // one lane, never split
    end else if (ex_i.size == lsu_op_pkg::TYPE_HALF) begin
      if (!ex_i.misaligned) begin
        case (addr_off)
          2'b00:   be = 4'b0011;
          2'b01:   be = 4'b0110;
          2'b10:   be = 4'b1100;
          default: be = 4'b1000;  // upper byte follows in the next word
        endcase
      end else begin
        be = 4'b0001;  // the byte left over from offset 3
      end
    end else begin
      // word
      if (!ex_i.misaligned) begin
        be = 4'b1111 << addr_off;  // lanes from the offset upwards
      end else begin
        case (addr_off)
          2'b00:   be = 4'b0000;  // cannot happen, an aligned word never splits
          2'b01:   be = 4'b0001;
          2'b10:   be = 4'b0011;
          default: be = 4'b0111;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // store data
  //////////////////////////////////////////////////

  // register byte reg_offset must land in lane addr_off
  assign wdata_off = addr_off - ex_i.reg_offset;

  always_comb begin
    case (wdata_off)
      2'b00:   wdata_rot = ex_i.wdata;
      2'b01:   wdata_rot = {ex_i.wdata[23:0], ex_i.wdata[31:24]};
      2'b10:   wdata_rot = {ex_i.wdata[15:0], ex_i.wdata[31:16]};
      default: wdata_rot = {ex_i.wdata[7:0],  ex_i.wdata[31:8]};
    endcase
  end

  //////////////////////////////////////////////////
  // split detection and outputs
  //////////////////////////////////////////////////

  // only the first half can raise the flag
  always_comb begin
    misaligned_o = 1'b0;
    if (!ex_i.misaligned) begin
      if (ex_i.size == lsu_op_pkg::TYPE_WORD) begin
        misaligned_o = (addr_off != 2'b00);   // word off its boundary
      end else if (ex_i.size == lsu_op_pkg::TYPE_HALF) begin
        misaligned_o = (addr_off == 2'b11);   // half crossing the word
      end
    end
  end

  // second half goes to the start of the next word
  assign bus_req_o.addr  = ex_i.misaligned ? {addr_int[31:2], 2'b00} : addr_int;
  assign bus_req_o.we    = ex_i.we;
  assign bus_req_o.be    = be;
  assign bus_req_o.wdata = wdata_rot;

  assign wb_ctrl_o.size   = ex_i.size;
  assign wb_ctrl_o.offset = addr_off;  // unaligned offset, also for the second half
  assign wb_ctrl_o.ext    = ex_i.ext;
  assign wb_ctrl_o.we     = ex_i.we;

endmodule

/* logic/lsu_top.sv */
// Load store unit top

`timescale 1ns/1ps

module lsu_top (
  input  logic                  clk,
  input  logic                  rst_n,

  // execute stage
  input  logic                  req_i,
  input  lsu_op_pkg::ex_req_t   ex_i,

  // data bus
  output logic                  data_req_o,
  input  logic                  gnt_i,
  input  logic                  rvalid_i,
  output lsu_bus_pkg::bus_req_t bus_o,
  input  lsu_bus_pkg::word_t    rdata_i,

  // back to the pipeline
  output lsu_bus_pkg::word_t    rdata_o,
  output logic                  misaligned_o,
  output logic                  lsu_ready_ex_o,
  output logic                  lsu_ready_wb_o,
  output logic                  busy_o
);

  lsu_op_pkg::wb_ctrl_t wb_ctrl_ex;  // control of the access in EX
  lsu_op_pkg::wb_ctrl_t wb_ctrl_wb;  // control of the access awaiting rvalid

  lsu_req_format u_req_format (
    .ex_i         (ex_i),
    .bus_req_o    (bus_o),
    .wb_ctrl_o    (wb_ctrl_ex),
    .misaligned_o (misaligned_o)
  );

  // bus ready is the grant itself
  lsu_txn_ctrl u_txn_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (req_i),
    .gnt_i      (gnt_i),
    .rvalid_i   (rvalid_i),
    .wb_ctrl_i  (wb_ctrl_ex),
    .data_req_o (data_req_o),
    .ready_ex_o (lsu_ready_ex_o),
    .ready_wb_o (lsu_ready_wb_o),
    .busy_o     (busy_o),
    .wb_ctrl_o  (wb_ctrl_wb)
  );

  lsu_rdata_align u_rdata_align (
    .clk            (clk),
    .rst_n          (rst_n),
    .rvalid_i       (rvalid_i),
    .rdata_i        (rdata_i),
    .wb_ctrl_i      (wb_ctrl_wb),
    .second_phase_i (ex_i.misaligned),
    .misaligned_i   (misaligned_o),
    .rdata_o        (rdata_o)
  );

endmodule

/* logic/lsu_txn_ctrl.sv */
// LSU transaction controller

`timescale 1ns/1ps

module lsu_txn_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req_i,       // EX wants a transfer
  input  logic                 gnt_i,       // bus took the address phase
  input  logic                 rvalid_i,    // bus response
  input  lsu_op_pkg::wb_ctrl_t wb_ctrl_i,   // control of the access in EX
  output logic                 data_req_o,
  output logic                 ready_ex_o,
  output logic                 ready_wb_o,
  output logic                 busy_o,
  output lsu_op_pkg::wb_ctrl_t wb_ctrl_o    // control of the access awaiting rvalid
);

  lsu_bus_pkg::cnt_t    cnt_q;      // transfers without a response
  lsu_bus_pkg::cnt_t    cnt_d;
  logic                 count_up;   // address phase accepted
  logic                 count_down; // response seen
  logic                 ctrl_update;
  lsu_op_pkg::wb_ctrl_t wb_ctrl_q;

  //////////////////////////////////////////////////
  // request and count
  //////////////////////////////////////////////////

  // no path from rvalid to req, the limit alone holds it off
  assign data_req_o = req_i && (cnt_q < lsu_bus_pkg::MAX_OUTSTANDING);

  assign count_up   = data_req_o && gnt_i;
  assign count_down = rvalid_i;  // one rvalid per accepted transfer

  always_comb begin
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + 2'd1;
      2'b01:   cnt_d = cnt_q - 2'd1;
      default: cnt_d = cnt_q;  // idle, or one in and one out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  //////////////////////////////////////////////////
  // stage handshakes
  //////////////////////////////////////////////////

  assign busy_o     = (cnt_q != '0) || data_req_o;
  assign ready_wb_o = (cnt_q == '0) ? 1'b1 : rvalid_i;  // WB empty or about to drain

  // EX moves only when WB can take its access in the same cycle
  always_comb begin
    if (!req_i) begin
      ready_ex_o = 1'b1;
    end else if (cnt_q == 2'd0) begin
      ready_ex_o = count_up;
    end else if (cnt_q == 2'd1) begin
      ready_ex_o = count_up && rvalid_i;
    end else begin
      ready_ex_o = rvalid_i;  // full, nothing can be issued this cycle
    end
  end

  assign ctrl_update = ready_ex_o && req_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ctrl_q <= '0;
    end else if (ctrl_update) begin
      wb_ctrl_q <= wb_ctrl_i;  // EX access becomes the WB access
    end
  end

  assign wb_ctrl_o = wb_ctrl_q;

endmodule

/* lsu_top.f */
logic/lsu_bus_pkg.sv
logic/lsu_op_pkg.sv
logic/lsu_req_format.sv
logic/lsu_txn_ctrl.sv
logic/lsu_rdata_align.sv
logic/lsu_top.sv
tests/lsu_checker.sv
tests/lsu_tb.sv

/* tests/lsu_checker.sv */
// LSU result checker

`timescale 1ns/1ps

module lsu_checker (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_i,
  input  lsu_op_pkg::ex_req_t   ex_i,
  input  logic                  data_req_i,
  input  logic                  gnt_i,
  input  logic                  rvalid_i,
  input  lsu_bus_pkg::bus_req_t bus_i,
  input  lsu_bus_pkg::word_t    lsu_rdata_i,  // DUT load result
  input  logic                  misaligned_i,
  input  logic                  ready_ex_i,
  input  logic                  ready_wb_i,
  input  logic                  busy_i,
  output int                    err_cnt_o,
  output int                    check_cnt_o
);

  logic [7:0]            shadow [64];  // byte image of the memory window
  lsu_bus_pkg::word_t    exp_q [$];    // expected result per granted transfer
  bit                    chk_q [$];    // 0 for stores and first halves
  int                    cnt;          // transfers without response
  lsu_bus_pkg::addr_t    start;
  lsu_bus_pkg::addr_t    first_addr;   // start of a split access
  lsu_bus_pkg::bus_req_t bus_q;
  logic                  stall_q;      // request left waiting for grant
  logic                  phase;
  logic                  split_exp;
  logic                  exp_ready;    // EX ready as the handshake rule gives it

  // load value from shadow bytes, extended by mode
  function automatic lsu_bus_pkg::word_t load_value(input lsu_bus_pkg::addr_t a,
      input lsu_op_pkg::lsu_type_t size, input lsu_op_pkg::ext_mode_t ext);
    int                 n;
    lsu_bus_pkg::word_t v;
    logic               fill;
    n = size[1] ? 1 : ((size == lsu_op_pkg::TYPE_HALF) ? 2 : 4);
    v = '0;
    for (int k = 0; k < n; k++) v[8*k +: 8] = shadow[6'(a + 32'(k))];
    if (n < 4) begin
      fill = (ext == 2'b00) ? 1'b0 : ((ext == 2'b10) ? 1'b1 : v[8*n-1]);
      for (int k = 8*n; k < 32; k++) v[k] = fill;
    end
    return v;
  endfunction

  // lanes from the offset up; the part above lane 3 goes to the next word
  function automatic lsu_bus_pkg::be_t lane_enables(input lsu_op_pkg::lsu_type_t size,
      input logic [1:0] off, input logic second);
    logic [7:0] m;
    m = size[1] ? 8'h01 : ((size == lsu_op_pkg::TYPE_HALF) ? 8'h03 : 8'h0f);
    m = m << off;
    return second ? m[7:4] : m[3:0];
  endfunction

  // register byte reg_off lands in lane off
  function automatic lsu_bus_pkg::word_t rotate_store(input lsu_bus_pkg::word_t d,
      input logic [1:0] off, input logic [1:0] reg_off);
    lsu_bus_pkg::word_t w;
    logic [1:0]         idx;
    for (int l = 0; l < 4; l++) begin
      idx = 2'(l) - off + reg_off;
      w[8*l +: 8] = d[8*idx +: 8];
    end
    return w;
  endfunction

  task automatic flag_error(input string msg);
    err_cnt_o++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  initial begin
    err_cnt_o = 0;
    check_cnt_o = 0;
    cnt = 0;
    stall_q = 1'b0;
    first_addr = '0;
    for (int i = 0; i < 64; i++) shadow[i] = 8'h00;  // memory model starts at zero
  end

  //////////////////////////////////////////////////
  // compare process
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      start = ex_i.use_incr ? (ex_i.operand_a + ex_i.operand_b) : ex_i.operand_a;
      phase = ex_i.misaligned;
      // handshake and count rules
      if (!req_i && data_req_i) flag_error("data_req without req");
      if (busy_i !== ((cnt != 0) || data_req_i)) flag_error("busy mismatch");
      if (!req_i) begin
        exp_ready = 1'b1;
      end else if (cnt == 0) begin
        exp_ready = gnt_i;  // taken as soon as the bus grants
      end else if (cnt == 1) begin
        exp_ready = gnt_i && rvalid_i;  // issue and drain together
      end else begin
        exp_ready = rvalid_i;  // already issued, waits for a free slot
      end
      if (ready_ex_i !== exp_ready) flag_error("EX ready wrong");
      // WB takes a result when empty or when the response arrives
      if (ready_wb_i !== ((cnt == 0) || rvalid_i)) flag_error("WB ready wrong");
      if (stall_q && (!data_req_i || bus_i !== bus_q)) flag_error("fields moved before grant");
      if (rvalid_i && cnt == 0) flag_error("rvalid with nothing outstanding");
      if (data_req_i && gnt_i) begin
        check_cnt_o++;
        split_exp = !phase && ((ex_i.size == lsu_op_pkg::TYPE_WORD && start[1:0] != 2'b00) ||
                               (ex_i.size == lsu_op_pkg::TYPE_HALF && start[1:0] == 2'b11));
        if (misaligned_i !== split_exp) flag_error("misaligned flag wrong");
        if (bus_i.addr !== (phase ? {start[31:2], 2'b00} : start)) flag_error("address wrong");
        if (bus_i.be !== lane_enables(ex_i.size, start[1:0], phase))
          flag_error("byte enables wrong");
        if (bus_i.we !== ex_i.we) flag_error("write enable wrong");
        if (bus_i.we) begin
          if (bus_i.wdata !== rotate_store(ex_i.wdata, start[1:0], ex_i.reg_offset))
            flag_error("store data not rotated correctly");
          for (int l = 0; l < 4; l++)
            if (bus_i.be[l]) shadow[{bus_i.addr[5:2], 2'(l)}] = bus_i.wdata[8*l +: 8];
          exp_q.push_back('0);
          chk_q.push_back(1'b0);
        end else if (split_exp) begin
          first_addr = start;  // result comes with the second half
          exp_q.push_back('0);
          chk_q.push_back(1'b0);
        end else begin
          exp_q.push_back(load_value(phase ? first_addr : start, ex_i.size, ex_i.ext));
          chk_q.push_back(1'b1);
        end
      end
      if (rvalid_i && exp_q.size() > 0) begin
        if (chk_q[0] && lsu_rdata_i !== exp_q[0])
          flag_error($sformatf("load got %h, expected %h", lsu_rdata_i, exp_q[0]));
        void'(exp_q.pop_front());
        void'(chk_q.pop_front());
      end
      cnt = cnt + int'(data_req_i && gnt_i) - int'(rvalid_i);
      if (cnt > 2) flag_error("more than two transfers outstanding");
      stall_q = data_req_i && !gnt_i;
      bus_q = bus_i;
    end
  end

endmodule

/* tests/lsu_tb.sv */
// LSU testbench

`timescale 1ns/1ps

module lsu_tb;

  localparam int          N_ACC       = 400;
  localparam int          TIMEOUT_CYC = N_ACC * 20;  // cycles before giving up
  localparam logic [31:0] SEED        = 32'h3ec89c25;

  logic                  clk;
  logic                  rst_n;
  logic                  req_i;
  lsu_op_pkg::ex_req_t   ex_i;
  logic                  data_req_o;
  logic                  gnt_i;
  logic                  rvalid_i;
  lsu_bus_pkg::bus_req_t bus_o;
  lsu_bus_pkg::word_t    rdata_i;
  lsu_bus_pkg::word_t    rdata_o;
  logic                  misaligned_o;
  logic                  lsu_ready_ex_o;
  logic                  lsu_ready_wb_o;
  logic                  busy_o;
  int                    err_cnt;
  int                    check_cnt;

  lsu_bus_pkg::word_t    mem [16];      // 64 byte window, address wraps
  lsu_bus_pkg::word_t    resp_data [$];
  int                    resp_due [$];  // cycle from which rvalid may show
  int                    cycle;
  int                    gnt_wait;
  int                    accepted;
  lsu_op_pkg::ex_req_t   ex;
  lsu_bus_pkg::addr_t    start;
  logic                  split;

  lsu_top u_dut (
    .clk(clk), .rst_n(rst_n), .req_i(req_i), .ex_i(ex_i),
    .data_req_o(data_req_o), .gnt_i(gnt_i), .rvalid_i(rvalid_i), .bus_o(bus_o),
    .rdata_i(rdata_i), .rdata_o(rdata_o), .misaligned_o(misaligned_o),
    .lsu_ready_ex_o(lsu_ready_ex_o), .lsu_ready_wb_o(lsu_ready_wb_o), .busy_o(busy_o)
  );

  lsu_checker u_checker (
    .clk(clk), .rst_n(rst_n), .req_i(req_i), .ex_i(ex_i), .data_req_i(data_req_o),
    .gnt_i(gnt_i), .rvalid_i(rvalid_i), .bus_i(bus_o), .lsu_rdata_i(rdata_o),
    .misaligned_i(misaligned_o), .ready_ex_i(lsu_ready_ex_o),
    .ready_wb_i(lsu_ready_wb_o), .busy_i(busy_o),
    .err_cnt_o(err_cnt), .check_cnt_o(check_cnt)
  );

  always #20 clk = ~clk;

  //////////////////////////////////////////////////
  // bus memory model
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rvalid_i) begin
      void'(resp_data.pop_front());
      void'(resp_due.pop_front());
    end
    if (data_req_o && gnt_i) begin
      for (int l = 0; l < 4; l++)
        if (bus_o.we && bus_o.be[l]) mem[bus_o.addr[5:2]][8*l +: 8] = bus_o.wdata[8*l +: 8];
      resp_data.push_back(mem[bus_o.addr[5:2]]);
      resp_due.push_back(cycle + 1 + int'($urandom_range(3, 0)));  // 1 to 4 cycles
      gnt_wait = int'($urandom_range(3, 0));
    end else if (gnt_wait > 0) begin
      gnt_wait--;
    end
    cycle++;
    #2;
    rvalid_i = (resp_due.size() > 0) && (resp_due[0] <= cycle);
    rdata_i  = rvalid_i ? resp_data[0] : $urandom;  // junk between responses
    // grant regardless of what is outstanding, the DUT holds off at its limit
    gnt_i = (gnt_wait == 0);
  end

  always @(posedge clk) begin
    if (cycle > TIMEOUT_CYC) begin
      $display("run timed out after %0d cycles", cycle);
      $display("TEST FAILED");
      $finish;
    end
  end

  // hold the access until EX is ready, called 2 ns after an edge
  task automatic send_access(input lsu_op_pkg::ex_req_t req, output logic was_split);
    req_i = 1'b1;
    ex_i  = req;
    do @(posedge clk); while (!lsu_ready_ex_o);
    was_split = misaligned_o;
    accepted++;
    #2;
  endtask

  initial begin
    void'($urandom(SEED));
    clk = 1'b0;
    rst_n = 1'b0;
    req_i = 1'b0;
    ex_i = '0;
    gnt_i = 1'b0;
    rvalid_i = 1'b0;
    rdata_i = '0;
    cycle = 0;
    gnt_wait = 0;
    accepted = 0;
    for (int i = 0; i < 16; i++) mem[i] = '0;
    repeat (10) @(posedge clk);
    #2 rst_n = 1'b1;
    for (int i = 0; i < N_ACC; i++) begin
      ex = '0;
      ex.we = 1'($urandom_range(1, 0));
      ex.size = 2'($urandom_range(3, 0));
      ex.wdata = $urandom;
      ex.reg_offset = 2'($urandom_range(3, 0));
      ex.ext = 2'($urandom_range(3, 0));
      start = {26'b0, 6'($urandom_range(63, 0))};
      ex.use_incr = 1'($urandom_range(1, 0));
      ex.operand_b = ex.use_incr ? 32'($urandom_range(64, 0)) : $urandom;
      ex.operand_a = ex.use_incr ? start - ex.operand_b : start;
      send_access(ex, split);
      if (split) begin
        ex.misaligned = 1'b1;  // next word, same low bits
        ex.use_incr = 1'b0;
        ex.operand_a = start + 32'd4;
        send_access(ex, split);
      end
      req_i = 1'b0;
      ex_i = '0;
      repeat ($urandom_range(1, 0)) begin
        @(posedge clk);
        #2;
      end
    end
    do @(posedge clk); while (busy_o);
    repeat (2) @(posedge clk);
    if (accepted != check_cnt) begin
      $display("accepted accesses and bus transfers do not match");
    end
    $display("accesses %0d, checked transfers %0d, errors %0d", accepted, check_cnt, err_cnt);
    if (err_cnt == 0 && accepted == check_cnt) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
